/* source/mem_wrap_consts.svh */
// memory stage constants
// request size codes, core and cache data widths

`ifndef MEM_WRAP_CONSTS_SVH
`define MEM_WRAP_CONSTS_SVH

// core data width
`define XLEN            32

// one returned data half from the L1.5
`define L15_LINE_W      64
`define LINE_WORDS      4       // 32-bit words per returned line

// request size field
`define MSG_SIZE_W      3
`define MSG_SIZE_0B     3'b000
`define MSG_SIZE_1B     3'b001
`define MSG_SIZE_2B     3'b010
`define MSG_SIZE_4B     3'b011

`endif

/* source/mem_op_pkg.sv */
// core side memory types
// opcode encoding from the execute stage and the decoded stage-6 access

`include "mem_wrap_consts.svh"

package mem_op_pkg;

    // bit 3 store, bits 2:1 width (11 word, 01 half, 10 byte), bit 0 signed
    typedef enum logic [3:0] {
        NONE = 4'b0000,
        SW   = 4'b1111,
        SH   = 4'b1011,
        SB   = 4'b1101,
        LW   = 4'b0111,
        LH   = 4'b0011,
        LHU  = 4'b0010,
        LB   = 4'b0101,
        LBU  = 4'b0100
    } mem_op_e;

    // access as it leaves stage 6
    typedef struct packed {
        logic               valid;          // any memory op present
        mem_op_e            op;
        logic [`XLEN-1:0]   addr;           // full byte address
        logic [`XLEN-1:0]   wdata;          // store word, core byte order
        logic [3:0]         be;             // be[0] is byte at offset 0
        logic               ld_misaligned;
        logic               st_misaligned;
    } mem_access_t;

endpackage

/* source/l15_pkg.sv */
// L1.5 cache side message types
// request and return encodings plus the two message structs

`include "mem_wrap_consts.svh"

package l15_pkg;

    // request types used by this core
    typedef enum logic [3:0] {
        LOAD_RQ  = 4'b0000,
        STORE_RQ = 4'b0001
    } l15_rqtype_e;

    // return types
    // INT_RET and anything else not matching is acked and dropped
    typedef enum logic [3:0] {
        LOAD_RET = 4'b0000,
        ST_ACK   = 4'b0100,
        INT_RET  = 4'b0111
    } l15_rettype_e;

    // core to cache request
    typedef struct packed {
        l15_rqtype_e            rqtype;
        logic [`MSG_SIZE_W-1:0] size;
        logic [31:0]            address;
        logic [31:0]            data;       // big endian byte order
    } l15_req_t;

    // cache to core return
    typedef struct packed {
        l15_rettype_e           returntype;
        logic [`L15_LINE_W-1:0] data_0;     // words 0 and 1, word 0 in upper half
        logic [`L15_LINE_W-1:0] data_1;     // words 2 and 3
    } l15_resp_t;

endpackage

/* source/load_align.sv */
// load data alignment
// picks the addressed word from the returned line, converts it to
// little endian and extends the byte, half or word as the op says

`timescale 1ns/100ps
`include "mem_wrap_consts.svh"

module load_align (
    input  l15_pkg::l15_resp_t  line,
    input  logic [3:0]          byte_addr,  // low address bits of the load
    input  mem_op_pkg::mem_op_e op,
    output logic [`XLEN-1:0]    load_word
);
    import mem_op_pkg::*;

    logic [`XLEN-1:0]   words [`LINE_WORDS];
    logic [`XLEN-1:0]   raw_word;
    logic [`XLEN-1:0]   le_word;
    logic [7:0]         sel_byte;
    logic [15:0]        sel_half;

    // big endian word order inside each half
    assign words[0] = line.data_0[`L15_LINE_W-1:`XLEN];
    assign words[1] = line.data_0[`XLEN-1:0];
    assign words[2] = line.data_1[`L15_LINE_W-1:`XLEN];
    assign words[3] = line.data_1[`XLEN-1:0];

    assign raw_word = words[byte_addr[3:2]];
    assign le_word  = {raw_word[7:0], raw_word[15:8], raw_word[23:16], raw_word[31:24]};

    assign sel_byte = le_word[8*byte_addr[1:0] +: 8];
    assign sel_half = le_word[16*byte_addr[1] +: 16];

    always_comb begin
        case (op)
            LB:      load_word = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            LBU:     load_word = {{(`XLEN-8){1'b0}}, sel_byte};
            LH:      load_word = {{(`XLEN-16){sel_half[15]}}, sel_half};
            LHU:     load_word = {{(`XLEN-16){1'b0}}, sel_half};
            LW:      load_word = le_word;
            default: load_word = '0;        // stores and no-op
        endcase
    end

endmodule

/* source/mem_decode.sv */
// memory access decode pipeline
// stage 5 registers the op and operands, stage 6 holds the decoded access
// with effective address, misalignment flags and store byte enables

`timescale 1ns/100ps
`include "mem_wrap_consts.svh"

module mem_decode (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    hold,       // freeze both stages
    input  mem_op_pkg::mem_op_e     mem_op,
    input  logic [`XLEN-1:0]        op_a,       // base register
    input  logic [`XLEN-1:0]        op_b,       // store source or load offset
    input  logic [`XLEN-1:0]        s_imm,      // store offset
    output mem_op_pkg::mem_access_t access
);
    import mem_op_pkg::*;

    // stage 5
    mem_op_e            op5;
    logic [`XLEN-1:0]   op_a5;
    logic [`XLEN-1:0]   op_b5;
    logic [`XLEN-1:0]   s_imm5;

    // between the stages
    logic               is_store5;
    logic               valid5;
    logic [`XLEN-1:0]   addr5;
    logic               mis5;
    logic [3:0]         be5;
    mem_access_t        access_nxt;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op5 <= NONE;
        end else if (!hold) begin
            op5 <= mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            op_a5  <= op_a;
            op_b5  <= op_b;
            s_imm5 <= s_imm;
        end
    end

    assign is_store5 = op5[3];
    assign valid5    = (op5 != NONE);

    // stores use the S immediate, loads the I immediate in op_b
    assign addr5 = is_store5 ? (op_a5 + s_imm5) : (op_a5 + op_b5);

    // half at odd address, or word not on a 4 byte boundary
    assign mis5 = (op5[1] & addr5[0]) | (op5[2] & op5[1] & addr5[1]);

    always_comb begin
        be5 = 4'b0000;
        if (is_store5 && !mis5) begin
            case (op5[2:1])
                2'b11:   be5 = 4'b1111;
                2'b01:   be5 = addr5[1] ? 4'b1100 : 4'b0011;
                2'b10:   be5 = 4'b0001 << addr5[1:0];
                default: be5 = 4'b0000;
            endcase
        end
    end

    always_comb begin
        access_nxt.valid         = valid5;
        access_nxt.op            = op5;
        access_nxt.addr          = addr5;
        access_nxt.wdata         = op_b5;
        access_nxt.be            = be5;
        access_nxt.ld_misaligned = mis5 & ~is_store5;
        access_nxt.st_misaligned = mis5 & is_store5;
    end

    // stage 6
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            access <= '0;
        end else if (!hold) begin
            access <= access_nxt;
        end
    end

endmodule

/* source/l15_bridge.sv */
// L1.5 request/response bridge
// sends the stage-6 access as one request, waits for the matching
// return and registers the load result with a done pulse

`timescale 1ns/100ps
`include "mem_wrap_consts.svh"

module l15_bridge (
    input  logic                    clk,
    input  logic                    nrst,
    input  mem_op_pkg::mem_access_t access,
    input  logic                    l15_header_ack,
    input  l15_pkg::l15_resp_t      l15_resp,
    input  logic                    l15_resp_val,
    output logic                    hold,
    output l15_pkg::l15_req_t       l15_req,
    output logic                    l15_req_val,
    output logic                    l15_resp_ack,
    output logic [`XLEN-1:0]        load_data,
    output logic                    op_done,
    output logic                    ld_misaligned,
    output logic                    st_misaligned
);
    import mem_op_pkg::*;
    import l15_pkg::*;

    typedef enum logic {
        s_idle,
        s_resp
    } state_e;

    state_e             state;
    mem_op_e            op_q;       // op of the request in flight
    logic [`XLEN-1:0]   addr_q;
    logic               req_fire;
    logic               resp_match;
    logic [`XLEN-1:0]   load_word;

    // only aligned accesses go out, and only one at a time
    assign l15_req_val = (state == s_idle) & access.valid
                       & ~access.ld_misaligned & ~access.st_misaligned;
    assign req_fire    = l15_req_val & l15_header_ack;

    // stage 6 may advance on the handshake edge, the next access waits there
    assign hold = (l15_req_val & ~l15_header_ack) | (state == s_resp);

    assign l15_resp_ack = (state == s_resp) & l15_resp_val;     // ack every return
    assign resp_match   = l15_resp_ack & (op_q[3] ? (l15_resp.returntype == ST_ACK)
                                                  : (l15_resp.returntype == LOAD_RET));

    assign ld_misaligned = (state == s_idle) & access.ld_misaligned;
    assign st_misaligned = (state == s_idle) & access.st_misaligned;

    // request message, stable as long as stage 6 is held
    always_comb begin
        l15_req.address = access.addr;
        if (access.op[3]) begin
            l15_req.rqtype = STORE_RQ;
            l15_req.data   = {access.wdata[7:0], access.wdata[15:8],
                              access.wdata[23:16], access.wdata[31:24]};
            case (access.be)
                4'b1111:                            l15_req.size = `MSG_SIZE_4B;
                4'b1100, 4'b0011:                   l15_req.size = `MSG_SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: l15_req.size = `MSG_SIZE_1B;
                default:                            l15_req.size = `MSG_SIZE_0B;
            endcase
        end else begin
            l15_req.rqtype = LOAD_RQ;
            l15_req.data   = '0;
            l15_req.size   = `MSG_SIZE_4B;      // always fetch the whole word
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state   <= s_idle;
            op_done <= 1'b0;
        end else begin
            op_done <= resp_match;
            case (state)
                s_idle:  if (req_fire) state <= s_resp;
                s_resp:  if (resp_match) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            op_q   <= access.op;
            addr_q <= access.addr;
        end
        if (resp_match && !op_q[3]) begin
            load_data <= load_word;             // kept until the next load
        end
    end

    load_align load_align_i (
        .line       (l15_resp),
        .byte_addr  (addr_q[3:0]),
        .op         (op_q),
        .load_word  (load_word)
    );

endmodule

/* source/mem_wrap.sv */
// memory stage top
// decode pipeline feeding the L1.5 bridge, busy goes back to the core

`timescale 1ns/100ps
`include "mem_wrap_consts.svh"

module mem_wrap (
    input  logic                    clk,
    input  logic                    nrst,
    input  mem_op_pkg::mem_op_e     mem_op,
    input  logic [`XLEN-1:0]        op_a,
    input  logic [`XLEN-1:0]        op_b,
    input  logic [`XLEN-1:0]        s_imm,
    output logic                    mem_busy,       // core holds its inputs
    // cache request
    output l15_pkg::l15_req_t       l15_req,
    output logic                    l15_req_val,
    input  logic                    l15_header_ack,
    // cache return
    input  l15_pkg::l15_resp_t      l15_resp,
    input  logic                    l15_resp_val,
    output logic                    l15_resp_ack,
    // results
    output logic [`XLEN-1:0]        load_data,
    output logic                    op_done,
    output logic                    ld_misaligned,
    output logic                    st_misaligned
);
    import mem_op_pkg::*;

    mem_access_t access6;       // stage-6 access

    mem_decode mem_decode_i (
        .clk        (clk),
        .nrst       (nrst),
        .hold       (mem_busy),
        .mem_op     (mem_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .s_imm      (s_imm),
        .access     (access6)
    );

    l15_bridge l15_bridge_i (
        .clk            (clk),
        .nrst           (nrst),
        .access         (access6),
        .l15_header_ack (l15_header_ack),
        .l15_resp       (l15_resp),
        .l15_resp_val   (l15_resp_val),
        .hold           (mem_busy),
        .l15_req        (l15_req),
        .l15_req_val    (l15_req_val),
        .l15_resp_ack   (l15_resp_ack),
        .load_data      (load_data),
        .op_done        (op_done),
        .ld_misaligned  (ld_misaligned),
        .st_misaligned  (st_misaligned)
    );

endmodule

/* dv/mem_wrap_asserts.sv */
// L1.5 bridge checker
// concurrent assertions on the request and return handshakes and on reset values

`timescale 1ns/100ps

module mem_wrap_asserts (
    input logic                 clk,
    input logic                 nrst,
    input l15_pkg::l15_req_t    l15_req,
    input logic                 l15_req_val,
    input logic                 l15_header_ack,
    input logic                 l15_resp_val,
    input logic                 l15_resp_ack,
    input logic                 op_done,
    input logic                 hold,
    input logic                 ld_misaligned,
    input logic                 st_misaligned
);
    int fail_count = 0;         // failed assertions so far
    logic in_flight;            // request accepted and not yet done

    // set on the header handshake and cleared by the done pulse
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            in_flight <= 1'b0;
        end else if (l15_req_val && l15_header_ack) begin
            in_flight <= 1'b1;
        end else if (op_done) begin
            in_flight <= 1'b0;
        end
    end

    // request held until the cache takes the header
    req_stable_a: assert property (@(posedge clk) disable iff (!nrst)
        l15_req_val && !l15_header_ack |=> l15_req_val && $stable(l15_req))
        else begin
            fail_count++;
            $error("request dropped or changed before header ack");
        end

    // returns are acked only while an accepted request is outstanding
    resp_ack_a: assert property (@(posedge clk) disable iff (!nrst)
        l15_resp_ack |-> l15_resp_val && in_flight)
        else begin
            fail_count++;
            $error("return acknowledged without a valid return or outside a request");
        end

    done_pulse_a: assert property (@(posedge clk) disable iff (!nrst)
        op_done |=> !op_done)
        else begin
            fail_count++;
            $error("op_done high for more than one cycle");
        end

    reset_low_a: assert property (@(posedge clk)
        !nrst |-> !l15_req_val && !l15_resp_ack && !op_done && !hold
                  && !ld_misaligned && !st_misaligned)
        else begin
            fail_count++;
            $error("bridge output active during reset");
        end

endmodule

/* dv/mem_wrap_tb.sv */
// testbench for the memory stage
// drives loads and stores against an L1.5 responder model and
// compares results with a byte array reference

`timescale 1ns/100ps
`include "mem_wrap_consts.svh"

module mem_wrap_tb;
    import mem_op_pkg::*;
    import l15_pkg::*;

    localparam logic [31:0] BASE = 32'h0001_2300;  // 64 byte window
    localparam int N_RANDOM   = 200;
    localparam int N_ACCESSES = 33 + N_RANDOM;
    localparam int LIMIT      = N_ACCESSES * 12;
    localparam int DONE_ST = 0;
    localparam int DONE_LD = 1;
    localparam int LD_MIS  = 2;
    localparam int ST_MIS  = 3;

    logic clk = 1'b0;
    logic nrst = 1'b1;                      // pulled low at time 0
    mem_op_e mem_op = NONE;
    logic [31:0] op_a = '0;
    logic [31:0] op_b = '0;
    logic [31:0] s_imm = '0;
    logic l15_header_ack = 1'b0;
    l15_resp_t l15_resp = '0;
    logic l15_resp_val = 1'b0;
    logic mem_busy;
    l15_req_t l15_req;
    logic l15_req_val;
    logic l15_resp_ack;
    logic [31:0] load_data;
    logic op_done;
    logic ld_misaligned;
    logic st_misaligned;

    logic [31:0] lfsr = 32'h6eda741a;
    logic [7:0] cache_mem [64];
    logic [7:0] ref_mem [64];
    mem_op_e rand_ops [8] = '{SW, SH, SB, LW, LH, LHU, LB, LBU};
    int exp_kind [$];
    logic [31:0] exp_data [$];
    string exp_name [$];
    l15_req_t exp_req [$];
    string exp_req_name [$];
    int issued = 0;
    int done_count = 0;
    int cycles = 0;

    mem_wrap mem_wrap_i (.*);

    bind l15_bridge mem_wrap_asserts bridge_asserts_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // expected load value from the little endian reference bytes
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [5:0] a);
        logic [7:0] b;
        logic [15:0] h;
        b = ref_mem[a];
        h = {ref_mem[a + 6'd1], ref_mem[a]};
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return {ref_mem[a + 6'd3], ref_mem[a + 6'd2], h};
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string nm, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch %s: expected %08h actual %08h", nm, exp, act));
        end
    endtask

    task automatic check_idle(input string nm);
        check(nm, 32'h0, {l15_req_val, l15_resp_ack, op_done, mem_busy,
                          ld_misaligned, st_misaligned});
    endtask

    // present one access, return once the DUT has taken it
    task automatic issue(input mem_op_e op, input logic [5:0] a, input logic [31:0] d,
                         input string nm);
        logic is_store;
        logic half;
        logic word;
        l15_req_t er;
        is_store = (op == SW) || (op == SH) || (op == SB);
        half = (op == SH) || (op == LH) || (op == LHU);
        word = (op == SW) || (op == LW);
        mem_op <= op;
        op_a <= BASE + {a[5:3], 3'b000};
        op_b <= is_store ? d : {29'b0, a[2:0]};
        s_imm <= is_store ? {29'b0, a[2:0]} : d;     // unused offset gets junk
        if ((half && a[0]) || (word && a[1:0] != 2'b00)) begin
            exp_kind.push_back(is_store ? ST_MIS : LD_MIS);
            exp_data.push_back('0);
        end else begin
            er.rqtype = is_store ? STORE_RQ : LOAD_RQ;
            er.size = (!is_store || word) ? `MSG_SIZE_4B : (half ? `MSG_SIZE_2B : `MSG_SIZE_1B);
            er.address = BASE + a;
            er.data = is_store ? {d[7:0], d[15:8], d[23:16], d[31:24]} : '0;
            exp_req.push_back(er);
            exp_req_name.push_back(nm);
            if (is_store) begin
                ref_mem[a] = d[7:0];
                if (!(op == SB)) ref_mem[a + 6'd1] = d[15:8];
                if (word) begin
                    ref_mem[a + 6'd2] = d[23:16];
                    ref_mem[a + 6'd3] = d[31:24];
                end
            end
            exp_kind.push_back(is_store ? DONE_ST : DONE_LD);
            exp_data.push_back(is_store ? 32'h0 : ref_load(op, a));
        end
        exp_name.push_back(nm);
        issued++;
        @(posedge clk);
        while (mem_busy) @(posedge clk);
    endtask

    task automatic take_result(input int seen);
        int k;
        logic [31:0] d;
        string nm;
        if (exp_kind.size() == 0) begin
            abort_run("completion seen with no access outstanding");
        end else begin
            k = exp_kind.pop_front();
            d = exp_data.pop_front();
            nm = exp_name.pop_front();
            // op_done alone does not tell load from store
            check({nm, " event"}, (k == DONE_LD) ? DONE_ST : k, seen);
            if (k == DONE_LD) check({nm, " load data"}, d, load_data);
            done_count++;
        end
    endtask

    task automatic check_request(input l15_req_t req);
        l15_req_t er;
        string nm;
        if (exp_req.size() == 0) begin
            abort_run("cache request sent with no aligned access outstanding");
        end else begin
            er = exp_req.pop_front();
            nm = exp_req_name.pop_front();
            check({nm, " rqtype"}, er.rqtype, req.rqtype);
            check({nm, " size"}, er.size, req.size);
            check({nm, " address"}, er.address, req.address);
            if (er.rqtype == STORE_RQ) check({nm, " store data"}, er.data, req.data);
        end
    endtask

    task automatic send_return(input l15_resp_t r);
        l15_resp <= r;
        l15_resp_val <= 1'b1;
        @(posedge clk);
        if (!l15_resp_ack) abort_run("cache return was not acknowledged");
        l15_resp_val <= 1'b0;
    endtask

    // L1.5 responder handling one request at a time
    initial begin : cache_model
        l15_req_t req;
        l15_resp_t ret;
        l15_resp_t junk;
        logic [127:0] line;
        logic [5:0] idx;
        int hdr_dly;
        int cnt;
        @(posedge nrst);
        forever begin
            hdr_dly = rand_bits(2);
            cnt = 0;
            l15_header_ack <= (hdr_dly == 0);
            @(posedge clk);
            while (!(l15_req_val && l15_header_ack)) begin
                if (l15_req_val) begin
                    cnt++;
                    if (cnt == hdr_dly) l15_header_ack <= 1'b1;
                end
                @(posedge clk);
            end
            req = l15_req;
            l15_header_ack <= 1'b0;
            check_request(req);
            idx = req.address[5:0];
            ret = '0;
            if (req.rqtype == STORE_RQ) begin
                cache_mem[idx] = req.data[31:24];
                if (req.size != `MSG_SIZE_1B) cache_mem[idx + 6'd1] = req.data[23:16];
                if (req.size == `MSG_SIZE_4B) begin
                    cache_mem[idx + 6'd2] = req.data[15:8];
                    cache_mem[idx + 6'd3] = req.data[7:0];
                end
                ret.returntype = ST_ACK;
            end else begin
                for (int k = 0; k < 16; k++) begin        // big endian words
                    line = {line[119:0], cache_mem[{idx[5:4], 4'(k)}]};
                end
                ret.returntype = LOAD_RET;
                ret.data_0 = line[127:64];
                ret.data_1 = line[63:0];
            end
            repeat (rand_bits(2)) @(posedge clk);
            if (rand_bits(2) == 0) begin
                junk.returntype = INT_RET;
                junk.data_0 = {rand_bits(32), rand_bits(32)};
                junk.data_1 = ~junk.data_0;
                send_return(junk);
            end
            send_return(ret);
        end
    end

    always @(negedge clk) begin : compare
        if (!nrst) begin
            check_idle("reset values");
        end else begin
            if (mem_wrap_i.l15_bridge_i.bridge_asserts_i.fail_count != 0) begin
                abort_run("an assertion on the bridge failed");
            end
            if (op_done) take_result(DONE_ST);
            if (ld_misaligned) take_result(LD_MIS);
            if (st_misaligned) take_result(ST_MIS);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) abort_run($sformatf("timeout after %0d cycles", cycles));
    end

    initial begin : stimulus
        logic [31:0] d;
        for (int i = 0; i < 64; i++) begin
            cache_mem[i] = 8'(i * 37) ^ 8'h5a;
            ref_mem[i] = 8'(i * 37) ^ 8'h5a;
        end
        nrst <= 1'b0;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_idle("after reset");
        @(posedge clk);
        for (int i = 0; i < 2; i++) begin
            issue(SW, 6'(8 + 4 * i), rand_bits(32), "word round trip");
            issue(LW, 6'(8 + 4 * i), rand_bits(32), "word round trip");
        end
        for (int off = 0; off < 4; off++) begin
            d = rand_bits(32);
            d[7] = off[0];                          // both sign cases
            issue(SB, 6'(16 + off), d, "byte half extension");
            issue(LB, 6'(16 + off), rand_bits(32), "byte half extension");
            issue(LBU, 6'(16 + off), rand_bits(32), "byte half extension");
        end
        for (int off = 0; off < 4; off += 2) begin
            d = rand_bits(32);
            d[15] = off[1];
            issue(SH, 6'(24 + off), d, "byte half extension");
            issue(LH, 6'(24 + off), rand_bits(32), "byte half extension");
            issue(LHU, 6'(24 + off), rand_bits(32), "byte half extension");
        end
        issue(LH, 6'd33, rand_bits(32), "misalignment");
        issue(LHU, 6'd35, rand_bits(32), "misalignment");
        issue(SH, 6'd37, rand_bits(32), "misalignment");
        issue(LW, 6'd41, rand_bits(32), "misalignment");
        issue(LW, 6'd42, rand_bits(32), "misalignment");
        issue(SW, 6'd43, rand_bits(32), "misalignment");
        issue(SW, 6'd45, rand_bits(32), "misalignment");
        for (int i = 0; i < 4; i++) begin          // region must be untouched
            issue(LW, 6'(32 + 4 * i), rand_bits(32), "misalignment");
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            issue(rand_ops[rand_bits(3)], 6'(rand_bits(6)), rand_bits(32), "random traffic");
        end
        mem_op <= NONE;
        wait (done_count == issued);
        repeat (4) @(posedge clk);
        if (!mem_busy && !l15_req_val) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("memory stage still busy or requesting at the end of the run");
        end
    end

endmodule

/* filelist.f */
+incdir+source
source/mem_op_pkg.sv
source/l15_pkg.sv
source/load_align.sv
source/mem_decode.sv
source/l15_bridge.sv
source/mem_wrap.sv
dv/mem_wrap_asserts.sv
dv/mem_wrap_tb.sv
